// File: Makefile
VERILATOR ?= verilator
TOP       ?= muldiv_tb
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= All checks passed

SOURCES := $(shell grep -v '^+' $(FILELIST)) $(wildcard logic/*.svh tb/*.svh)
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "^$(PASS_MSG)$$" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: logic/lead_one_pos.sv
`timescale 1ns/1ns
`default_nettype none

`include "muldiv_params.svh"

// bit length of a word, zero for a zero word
module lead_one_pos (
    input  logic [`MD_XLEN-1:0]  value,
    output logic [`MD_LEN_W-1:0] len
);

    always_comb begin
        len = '0;
        for (int i = 0; i < `MD_XLEN; i++) begin
            if (value[i]) begin
                len = `MD_LEN_W'(i + 1);  // higher bits overwrite lower ones
            end
        end
    end

endmodule

`default_nettype wire

// File: logic/muldiv_params.svh
`ifndef MULDIV_PARAMS_SVH
`define MULDIV_PARAMS_SVH

// operand and result width
`define MD_XLEN 32

// destination register tag
`define MD_TAG_W 5

// bit-length value, holds 0 to MD_XLEN
`define MD_LEN_W 6

// multiplier pipeline depth
`define MD_MUL_STAGES 2

`endif

// File: logic/muldiv_pkg.sv
`default_nettype none

`include "muldiv_params.svh"

package muldiv_pkg;

    // upper bit selects the divider
    typedef enum logic [1:0] {
        mul_lo  = 2'b00,
        mul_hi  = 2'b01,
        div_quo = 2'b10,
        div_rem = 2'b11
    } md_op_e;

    typedef struct packed {
        md_op_e               op;
        logic                 is_signed;
        logic [`MD_XLEN-1:0]  a;         // dividend or multiplicand
        logic [`MD_XLEN-1:0]  b;         // divisor or multiplier
        logic [`MD_TAG_W-1:0] tag;       // destination register
    } md_req_t;

    typedef struct packed {
        logic [`MD_XLEN-1:0]  result;
        logic [`MD_TAG_W-1:0] tag;
    } md_resp_t;

endpackage

`default_nettype wire

// File: logic/muldiv_unit.sv
`timescale 1ns/1ns
`default_nettype none

module muldiv_unit import muldiv_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  md_req_t  req,
    input  logic     req_valid,
    output logic     req_ready,
    output md_resp_t resp,
    output logic     resp_valid,
    input  logic     resp_ready
);

    logic     sel_div;
    logic     div_valid;
    logic     div_req_ready;
    logic     mul_valid;
    logic     mul_req_ready;

    md_resp_t div_resp;
    logic     div_resp_valid;
    logic     div_resp_ready;
    md_resp_t mul_resp;
    logic     mul_resp_valid;
    logic     mul_resp_ready;

    assign sel_div   = req.op[1];                 // div_quo / div_rem
    assign div_valid = req_valid & sel_div;
    assign mul_valid = req_valid & !sel_div;
    assign req_ready = sel_div ? div_req_ready : mul_req_ready;

    seq_divider u_div (
        .clk        (clk),
        .rst_n      (rst_n),
        .req        (req),
        .req_valid  (div_valid),
        .req_ready  (div_req_ready),
        .resp       (div_resp),
        .resp_valid (div_resp_valid),
        .resp_ready (div_resp_ready)
    );

    pipe_multiplier u_mul (
        .clk        (clk),
        .rst_n      (rst_n),
        .req        (req),
        .req_valid  (mul_valid),
        .req_ready  (mul_req_ready),
        .resp       (mul_resp),
        .resp_valid (mul_resp_valid),
        .resp_ready (mul_resp_ready)
    );

    wb_merge u_merge (
        .div_resp   (div_resp),
        .div_valid  (div_resp_valid),
        .div_ready  (div_resp_ready),
        .mul_resp   (mul_resp),
        .mul_valid  (mul_resp_valid),
        .mul_ready  (mul_resp_ready),
        .resp       (resp),
        .resp_valid (resp_valid),
        .resp_ready (resp_ready)
    );

endmodule

`default_nettype wire

// File: logic/pipe_multiplier.sv
`timescale 1ns/1ns
`default_nettype none

`include "muldiv_params.svh"

module pipe_multiplier import muldiv_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  md_req_t  req,
    input  logic     req_valid,
    output logic     req_ready,
    output md_resp_t resp,
    output logic     resp_valid,
    input  logic     resp_ready
);

    logic                          advance;

    logic                          s1_valid;
    logic signed [`MD_XLEN:0]      s1_a;      // sign or zero extended
    logic signed [`MD_XLEN:0]      s1_b;
    logic                          s1_hi;
    logic [`MD_TAG_W-1:0]          s1_tag;

    logic signed [2*`MD_XLEN+1:0]  full;
    logic                          s2_valid;
    logic [2*`MD_XLEN-1:0]         prod_q;
    logic                          s2_hi;
    logic [`MD_TAG_W-1:0]          s2_tag;

    // whole pipe moves when the output slot frees up
    assign advance   = !s2_valid || resp_ready;
    assign req_ready = advance;

    assign full = s1_a * s1_b;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
        end else if (advance) begin
            s1_valid <= req_valid;
            s2_valid <= s1_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            s1_a   <= {req.is_signed & req.a[`MD_XLEN-1], req.a};
            s1_b   <= {req.is_signed & req.b[`MD_XLEN-1], req.b};
            s1_hi  <= (req.op == mul_hi);
            s1_tag <= req.tag;
            prod_q <= full[2*`MD_XLEN-1:0];
            s2_hi  <= s1_hi;
            s2_tag <= s1_tag;
        end
    end

    assign resp.result = s2_hi ? prod_q[2*`MD_XLEN-1:`MD_XLEN] : prod_q[`MD_XLEN-1:0];
    assign resp.tag    = s2_tag;
    assign resp_valid  = s2_valid;

    a_resp_hold: assert property (@(posedge clk) disable iff (!rst_n)
        resp_valid && !resp_ready |=> resp_valid && $stable(resp))
        else $error("multiplier result changed under back-pressure");

endmodule

`default_nettype wire

// File: logic/seq_divider.sv
`timescale 1ns/1ns
`default_nettype none

`include "muldiv_params.svh"

module seq_divider import muldiv_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  md_req_t  req,
    input  logic     req_valid,
    output logic     req_ready,
    output md_resp_t resp,
    output logic     resp_valid,
    input  logic     resp_ready
);

    logic                 a_neg;
    logic                 b_neg;
    logic [`MD_XLEN-1:0]  a_mag;
    logic [`MD_XLEN-1:0]  b_mag;
    logic [`MD_LEN_W-1:0] a_len;
    logic [`MD_LEN_W-1:0] b_len;
    logic [`MD_LEN_W-1:0] len_diff;
    logic                 early;
    logic                 accept;

    logic [`MD_LEN_W-1:0] cnt;       // iterations left plus the sign-fix cycle
    logic [`MD_XLEN-1:0]  rem_q;
    logic [`MD_XLEN-1:0]  dvs_q;
    logic [`MD_XLEN-1:0]  quo_q;
    logic                 want_rem;
    logic                 neg_quo;
    logic                 neg_rem;
    logic [`MD_TAG_W-1:0] tag_q;

    assign a_neg = req.is_signed & req.a[`MD_XLEN-1];
    assign b_neg = req.is_signed & req.b[`MD_XLEN-1];
    assign a_mag = a_neg ? -req.a : req.a;
    assign b_mag = b_neg ? -req.b : req.b;

    lead_one_pos u_len_a (
        .value (a_mag),
        .len   (a_len)
    );

    lead_one_pos u_len_b (
        .value (b_mag),
        .len   (b_len)
    );

    // zero divisor or divisor longer than dividend answers at once
    assign early    = (b_len == '0) || (b_len > a_len);
    assign len_diff = a_len - b_len;

    assign req_ready = (cnt == '0) && !resp_valid;
    assign accept    = req_valid && req_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt        <= '0;
            resp_valid <= 1'b0;
        end else begin
            if (accept && !early) begin
                cnt <= len_diff + `MD_LEN_W'd2;
            end else if (cnt != '0) begin
                cnt <= cnt - `MD_LEN_W'd1;
            end

            if (accept && early) begin
                resp_valid <= 1'b1;
            end else if (cnt == `MD_LEN_W'd1) begin
                resp_valid <= 1'b1;          // sign fix done
            end else if (resp_ready) begin
                resp_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            tag_q    <= req.tag;
            want_rem <= (req.op == div_rem);
            neg_quo  <= a_neg ^ b_neg;
            neg_rem  <= a_neg;               // remainder follows the dividend
            rem_q    <= a_mag;
            dvs_q    <= b_mag << len_diff;   // align top bits
            quo_q    <= '0;
            if (early) begin
                resp.result <= (req.op == div_rem) ? req.a : '0;
                resp.tag    <= req.tag;
            end
        end else if (cnt > `MD_LEN_W'd1) begin
            if (rem_q >= dvs_q) begin
                rem_q <= rem_q - dvs_q;
                quo_q <= {quo_q[`MD_XLEN-2:0], 1'b1};
            end else begin
                quo_q <= {quo_q[`MD_XLEN-2:0], 1'b0};
            end
            dvs_q <= dvs_q >> 1;
        end else if (cnt == `MD_LEN_W'd1) begin
            if (want_rem) begin
                resp.result <= neg_rem ? -rem_q : rem_q;
            end else begin
                resp.result <= neg_quo ? -quo_q : quo_q;
            end
            resp.tag <= tag_q;
        end
    end

    a_resp_hold: assert property (@(posedge clk) disable iff (!rst_n)
        resp_valid && !resp_ready |=> resp_valid && $stable(resp))
        else $error("divider result changed under back-pressure");

    a_busy_no_result: assert property (@(posedge clk) disable iff (!rst_n)
        resp_valid |-> cnt == '0)
        else $error("divider result raised while still iterating");

endmodule

`default_nettype wire

// File: logic/wb_merge.sv
`timescale 1ns/1ns
`default_nettype none

// divider wins, multiplier waits
module wb_merge import muldiv_pkg::*; (
    input  md_resp_t div_resp,
    input  logic     div_valid,
    output logic     div_ready,
    input  md_resp_t mul_resp,
    input  logic     mul_valid,
    output logic     mul_ready,
    output md_resp_t resp,
    output logic     resp_valid,
    input  logic     resp_ready
);

    assign resp       = div_valid ? div_resp : mul_resp;
    assign resp_valid = div_valid | mul_valid;

    assign div_ready  = div_valid & resp_ready;
    assign mul_ready  = !div_valid & resp_ready;  // blocked behind a divider result

endmodule

`default_nettype wire

// File: project.f
+incdir+logic
+incdir+tb
logic/muldiv_pkg.sv
logic/lead_one_pos.sv
logic/seq_divider.sv
logic/pipe_multiplier.sv
logic/wb_merge.sv
logic/muldiv_unit.sv
tb/muldiv_tb.sv

// File: tb/muldiv_model.svh
// expected result per tag, written when the request transfers
logic [`MD_XLEN-1:0] exp_result [1 << `MD_TAG_W];
logic                pending    [1 << `MD_TAG_W];
int                  zero_div_cnt;
int                  short_div_cnt;
logic                early_due;                // single-cycle answer due next edge
logic [`MD_TAG_W-1:0] early_tag;

task automatic abort_run(input string why);
    $display("%s", why);
    $display("Checks failed");
    $fatal(1, "simulation stopped");
endtask

task automatic check_equal(input string name, input logic [`MD_XLEN-1:0] got,
                           input logic [`MD_XLEN-1:0] exp);
    if (got !== exp) begin
        abort_run($sformatf("FAIL time=%0t %s got=%h expected=%h", $time, name, got, exp));
    end
endtask

// truncating division, remainder keeps the dividend sign, x/0 gives q=0 r=a
function automatic logic [`MD_XLEN-1:0] model_result(input md_req_t r);
    logic signed [2*`MD_XLEN-1:0] sa;
    logic signed [2*`MD_XLEN-1:0] sb;
    logic signed [2*`MD_XLEN-1:0] prod;
    if (r.is_signed) begin
        sa = $signed(r.a);                   // sign extends to 64 bits
        sb = $signed(r.b);
    end else begin
        sa = {{`MD_XLEN{1'b0}}, r.a};
        sb = {{`MD_XLEN{1'b0}}, r.b};
    end
    prod = sa * sb;                          // low 64 bits are exact either way
    case (r.op)
        mul_lo:  return prod[`MD_XLEN-1:0];
        mul_hi:  return prod[2*`MD_XLEN-1:`MD_XLEN];
        div_quo: return (sb == 0) ? '0 : `MD_XLEN'(sa / sb);
        default: return (sb == 0) ? r.a : `MD_XLEN'(sa % sb);
    endcase
endfunction

// divisions that should answer on the cycle after they transfer
task automatic note_div_path(input md_req_t r);
    logic [`MD_XLEN-1:0] ma;
    logic [`MD_XLEN-1:0] mb;
    ma = (r.is_signed && r.a[`MD_XLEN-1]) ? -r.a : r.a;
    mb = (r.is_signed && r.b[`MD_XLEN-1]) ? -r.b : r.b;
    if (r.op == div_quo || r.op == div_rem) begin
        if (mb == '0) begin
            zero_div_cnt++;
            early_due = 1'b1;
            early_tag = r.tag;
        end else if ($clog2({1'b0, mb} + 1) > $clog2({1'b0, ma} + 1)) begin
            short_div_cnt++;                 // divisor longer than dividend
            early_due = 1'b1;
            early_tag = r.tag;
        end
    end
endtask

// File: tb/muldiv_tb.sv
`timescale 1ns/1ns
`default_nettype none

`include "muldiv_params.svh"

module muldiv_tb import muldiv_pkg::*; ();

    localparam int NUM_REQS        = 2000;
    localparam int WATCHDOG_CYCLES = NUM_REQS * 40;

    logic     clk;
    logic     rst_n;
    md_req_t  req;
    logic     req_valid;
    logic     req_ready;
    md_resp_t resp;
    logic     resp_valid;
    logic     resp_ready;

    integer               seed;
    logic [`MD_TAG_W-1:0] next_tag;
    int                   presented;
    int                   done_count;
    int                   ooo_count;     // responses that overtook an older request
    int                   issue_order [$];

    `include "muldiv_model.svh"

    muldiv_unit u_dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .req        (req),
        .req_valid  (req_valid),
        .req_ready  (req_ready),
        .resp       (resp),
        .resp_valid (resp_valid),
        .resp_ready (resp_ready)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // zero, most negative, all ones, small, or random of random length
    function automatic logic [`MD_XLEN-1:0] rand_operand();
        int pick;
        pick = {$random(seed)} % 8;
        case (pick)
            0:       return '0;
            1:       return {1'b1, {(`MD_XLEN-1){1'b0}}};
            2:       return '1;
            3:       return `MD_XLEN'({$random(seed)} % 256);
            default: return $random(seed) >> ({$random(seed)} % `MD_XLEN);
        endcase
    endfunction

    function automatic md_req_t random_request(input logic [`MD_TAG_W-1:0] tag);
        md_req_t     r;
        logic [31:0] rnd;
        rnd         = $random(seed);
        r.op        = md_op_e'(rnd[1:0]);
        r.is_signed = rnd[2];
        r.a         = rand_operand();
        r.b         = rand_operand();
        r.tag       = tag;
        return r;
    endfunction

    task automatic collect_response();
        if (early_due) begin
            // divider has priority, so its single-cycle answer shows at once
            check_equal("resp_valid", resp_valid, 1'b1);
            check_equal("resp.tag", resp.tag, early_tag);
            early_due = 1'b0;
        end
        if (resp_valid && resp_ready) begin
            if (!pending[resp.tag]) begin
                abort_run($sformatf("response with tag %0d that was not outstanding", resp.tag));
            end else begin
                check_equal("resp.result", resp.result, exp_result[resp.tag]);
                pending[resp.tag] = 1'b0;
                if (issue_order[0] != int'(resp.tag)) begin
                    ooo_count++;
                end
                for (int i = 0; i < issue_order.size(); i++) begin
                    if (issue_order[i] == int'(resp.tag)) begin
                        issue_order.delete(i);
                        break;
                    end
                end
                done_count++;
            end
        end
    endtask

    task automatic drive_request();
        md_req_t r;
        if (req_valid && req_ready) begin
            exp_result[req.tag] = model_result(req);
            pending[req.tag]    = 1'b1;
            note_div_path(req);
            issue_order.push_back(int'(req.tag));
        end
        if (!req_valid || req_ready) begin
            if (presented < NUM_REQS && !pending[next_tag]) begin
                r          = random_request(next_tag);
                req       <= r;
                req_valid <= 1'b1;
                next_tag   = next_tag + 1'b1;
                presented++;
            end else begin
                req_valid <= 1'b0;
            end
        end
    endtask

    initial begin
        seed          = 88;
        rst_n         = 1'b0;
        req           = '0;
        req_valid     = 1'b0;
        resp_ready    = 1'b0;
        next_tag      = '0;
        presented     = 0;
        done_count    = 0;
        ooo_count     = 0;
        zero_div_cnt  = 0;
        short_div_cnt = 0;
        early_due     = 1'b0;
        early_tag     = '0;
        foreach (pending[i]) begin
            pending[i] = 1'b0;
        end
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;

        while (done_count < NUM_REQS) begin
            @(posedge clk);
            collect_response();
            drive_request();
            resp_ready <= ({$random(seed)} % 3) != 0;   // low about a third of the time
        end

        if (ooo_count > 0 && zero_div_cnt > 0 && short_div_cnt > 0) begin
            $display("All checks passed");
            $finish;
        end else begin
            abort_run($sformatf({"run incomplete: %0d out-of-order responses, ",
                "%0d zero divisors, %0d short divisors"},
                ooo_count, zero_div_cnt, short_div_cnt));
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        abort_run($sformatf("watchdog expired after %0d cycles with %0d of %0d responses",
            WATCHDOG_CYCLES, done_count, NUM_REQS));
    end

endmodule

`default_nettype wire
